/* common/opl3_defs.svh */
// OPL3 operator sizing macros

`ifndef OPL3_DEFS_SVH
`define OPL3_DEFS_SVH

// sample rate divide
`define SAMPLE_DIV 32  // system clocks per sample

// register field widths
`define FNUM_WIDTH 10  // frequency number
`define MULT_WIDTH 4   // frequency multiplier
`define BLOCK_WIDTH 3  // octave block
`define WS_WIDTH 2     // waveform select
`define ENV_WIDTH 4    // ar, dr, sl, rr
`define TL_WIDTH 6     // total level

// datapath widths
`define ATT_WIDTH 9     // attenuation, 0 loud .. 511 silent
`define PHASE_WIDTH 20  // phase accumulator
`define OUT_WIDTH 13    // signed output sample

`endif

/* common/opl3_pkg.sv */
// OPL3 operator shared types

`include "opl3_defs.svh"

package opl3_pkg;

    // phase word split for the sine lookup
    typedef struct packed {
        logic [1:0] quadrant;  // which quarter of the wave
        logic [7:0] index;     // quarter-sine table address
        logic [9:0] frac;      // sub-index phase, not looked up
    } phase_fields_t;

    // same accumulator word seen two ways
    typedef union packed {
        logic [`PHASE_WIDTH-1:0] raw;  // accumulator view
        phase_fields_t fields;         // lookup view
    } phase_t;

    // envelope generator states
    typedef enum logic [2:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

endpackage

/* verilog/sample_clk_div.sv */
// Sample rate enable divider

`timescale 1ns/1ps
`include "opl3_defs.svh"

module sample_clk_div (
    input  logic clk,
    input  logic rst_n,
    output logic sample_en  // one clock wide, once per sample
);

    localparam int CNT_W = $clog2(`SAMPLE_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // pulse is registered, so the first one lands SAMPLE_DIV clocks after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            sample_en <= 1'b0;
        end else begin
            sample_en <= (cnt == CNT_LAST);  // wrap strobe
            if (cnt == CNT_LAST) begin
                cnt <= '0;  // modulo wrap
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* operator/phase_generator.sv */
// Operator phase accumulator

`timescale 1ns/1ps
`include "opl3_defs.svh"

module phase_generator
    import opl3_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sample_en,
    input  logic [`FNUM_WIDTH-1:0]  fnum,
    input  logic [`MULT_WIDTH-1:0]  mult,
    input  logic [`BLOCK_WIDTH-1:0] block,
    output phase_t                  phase
);

    // fnum shifted by the largest block, then times the largest mult
    localparam int SHIFT_W = `FNUM_WIDTH + (1 << `BLOCK_WIDTH) - 1;
    localparam int PROD_W  = SHIFT_W + `MULT_WIDTH;

    logic [SHIFT_W-1:0] fnum_shifted;  // octave scaled fnum
    logic [PROD_W-1:0]  step_full;     // per-sample increment

    always_comb begin
        fnum_shifted = SHIFT_W'(fnum) << block;  // one octave per block step
        if (mult == '0) begin
            step_full = PROD_W'(fnum_shifted >> 1);  // mult 0 means x0.5
        end else begin
            step_full = fnum_shifted * mult;
        end
    end

    // stage 1, phase moves once per sample and wraps freely
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (sample_en) begin
            phase.raw <= phase.raw + step_full[`PHASE_WIDTH-1:0];  // modulo add
        end
    end

endmodule

/* operator/envelope_generator.sv */
// ADSR envelope generator

`timescale 1ns/1ps
`include "opl3_defs.svh"

module envelope_generator
    import opl3_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sample_en,
    input  logic                  kon,  // key on level
    input  logic                  egt,  // hold at sustain level when set
    input  logic [`ENV_WIDTH-1:0] ar,
    input  logic [`ENV_WIDTH-1:0] dr,
    input  logic [`ENV_WIDTH-1:0] sl,
    input  logic [`ENV_WIDTH-1:0] rr,
    output logic [`ATT_WIDTH-1:0] att  // 0 loud, all ones silent
);

    localparam logic [`ATT_WIDTH-1:0] ATT_MAX = '1;

    env_state_t state;
    logic       kon_q;  // kon as seen at the previous sample

    logic [`ATT_WIDTH-1:0] ar_step;    // attack step, ar x4
    logic [`ATT_WIDTH-1:0] sl_level;   // sustain target, sl x32
    logic [`ATT_WIDTH:0]   att_up_dr;  // extra bit catches overflow
    logic [`ATT_WIDTH:0]   att_up_rr;

    assign ar_step   = `ATT_WIDTH'({ar, 2'b00});
    assign sl_level  = `ATT_WIDTH'({sl, 5'b00000});
    assign att_up_dr = att + dr;
    assign att_up_rr = att + rr;

    // stage 1, stepped once per sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENV_IDLE;
            att   <= ATT_MAX;  // silent
            kon_q <= 1'b0;
        end else if (sample_en) begin
            kon_q <= kon;
            if (kon && !kon_q) begin
                state <= ENV_ATTACK;  // retrigger from the current level
            end else if (!kon && kon_q) begin
                state <= ENV_RELEASE;
            end else begin
                case (state)
                    ENV_ATTACK: begin
                        if (ar != '0) begin  // rate 0 holds
                            if (att <= ar_step) begin
                                att   <= '0;  // full level reached
                                state <= ENV_DECAY;
                            end else begin
                                att <= att - ar_step;
                            end
                        end
                    end
                    ENV_DECAY: begin
                        if (dr != '0) begin
                            if (att_up_dr >= {1'b0, sl_level}) begin
                                att   <= sl_level;  // clamp at sustain level
                                state <= egt ? ENV_SUSTAIN : ENV_RELEASE;
                            end else begin
                                att <= att_up_dr[`ATT_WIDTH-1:0];
                            end
                        end
                    end
                    ENV_SUSTAIN: begin
                        if (!egt) begin
                            state <= ENV_RELEASE;  // non-sustaining, keep falling
                        end
                    end
                    ENV_RELEASE: begin
                        if (rr != '0) begin
                            if (att_up_rr >= {1'b0, ATT_MAX}) begin
                                att   <= ATT_MAX;
                                state <= ENV_IDLE;  // fully silent
                            end else begin
                                att <= att_up_rr[`ATT_WIDTH-1:0];
                            end
                        end
                    end
                    ENV_IDLE: att <= ATT_MAX;
                    default:  state <= ENV_IDLE;
                endcase
            end
        end
    end

endmodule

/* operator/waveform_lookup.sv */
// Sine waveform lookup and attenuation

`timescale 1ns/1ps
`include "opl3_defs.svh"

module waveform_lookup
    import opl3_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  phase_t                       phase,
    input  logic [`WS_WIDTH-1:0]         ws,
    input  logic [`TL_WIDTH-1:0]         tl,
    input  logic [`ATT_WIDTH-1:0]        att,
    output logic signed [`OUT_WIDTH-1:0] out
);

    localparam int     MAG_W     = `OUT_WIDTH - 1;  // magnitude bits
    localparam int     ROM_DEPTH = 256;
    localparam longint SPAN      = 4 * ROM_DEPTH;   // half period in half-steps
    localparam longint SINE_PEAK = (1 << MAG_W) - 1;

    // rational sine approximation at entry centres, computed at elaboration
    function automatic logic [MAG_W-1:0] sine_entry(input int idx);
        longint p;
        longint num;
        longint den;
        p   = longint'(2 * idx + 1) * (SPAN - 1 - longint'(2 * idx));
        num = SINE_PEAK * 16 * p;
        den = 5 * SPAN * SPAN - 4 * p;
        return MAG_W'((num + den / 2) / den);
    endfunction

    logic [MAG_W-1:0] sine_rom [ROM_DEPTH];

    for (genvar i = 0; i < ROM_DEPTH; i++) begin : g_rom
        assign sine_rom[i] = sine_entry(i);  // constant quarter wave
    end

    logic [7:0]            rom_addr;
    logic                  neg;     // negative half of the wave
    logic                  mute;    // waveform blanks this quadrant
    logic [`ATT_WIDTH:0]   att_sum; // att plus tl x4, one carry bit
    logic [`ATT_WIDTH-1:0] att_sat;

    always_comb begin
        rom_addr = phase.fields.quadrant[0] ? ~phase.fields.index : phase.fields.index;
        neg      = phase.fields.quadrant[1];
        mute     = 1'b0;
        case (ws)
            2'd0: mute = 1'b0;  // full sine
            2'd1: mute = neg;   // half sine
            2'd2: neg = 1'b0;   // absolute sine
            default: begin      // quarter pulses
                mute = phase.fields.quadrant[0];
                neg  = 1'b0;
            end
        endcase
        att_sum = att + {tl, 2'b00};
        att_sat = att_sum[`ATT_WIDTH] ? '1 : att_sum[`ATT_WIDTH-1:0];  // saturate
    end

    logic [MAG_W-1:0]         mag_q;   // stage 2 table value
    logic                     neg_q;
    logic [`ATT_WIDTH-1:0]    gain_q;  // 511 minus attenuation
    logic [MAG_W+`ATT_WIDTH-1:0] prod;
    logic [MAG_W-1:0]         scaled;

    assign prod   = mag_q * gain_q;
    assign scaled = prod[MAG_W+`ATT_WIDTH-1:`ATT_WIDTH];  // >> 9

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mag_q  <= '0;
            neg_q  <= 1'b0;
            gain_q <= '0;
            out    <= '0;
        end else begin
            mag_q  <= mute ? '0 : sine_rom[rom_addr];  // stage 2
            neg_q  <= neg;
            gain_q <= ~att_sat;
            out    <= neg_q ? -$signed({1'b0, scaled}) : $signed({1'b0, scaled});  // stage 3
        end
    end

endmodule

/* operator/opl3_operator.sv */
// OPL3 FM operator top level

`timescale 1ns/1ps
`include "opl3_defs.svh"

module opl3_operator
    import opl3_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         kon,
    input  logic                         egt,
    input  logic [`FNUM_WIDTH-1:0]       fnum,
    input  logic [`MULT_WIDTH-1:0]       mult,
    input  logic [`BLOCK_WIDTH-1:0]      block,
    input  logic [`WS_WIDTH-1:0]         ws,
    input  logic [`ENV_WIDTH-1:0]        ar,
    input  logic [`ENV_WIDTH-1:0]        dr,
    input  logic [`ENV_WIDTH-1:0]        sl,
    input  logic [`ENV_WIDTH-1:0]        rr,
    input  logic [`TL_WIDTH-1:0]         tl,
    output logic signed [`OUT_WIDTH-1:0] out,
    output logic                         sample_valid  // out is new this cycle
);

    logic                  sample_en;
    phase_t                phase;
    logic [`ATT_WIDTH-1:0] att;
    logic [2:0]            valid_sr;  // tracks sample_en through stages 1..3

    sample_clk_div u_sample_clk_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en)
    );

    phase_generator u_phase_generator (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .fnum      (fnum),
        .mult      (mult),
        .block     (block),
        .phase     (phase)
    );

    envelope_generator u_envelope_generator (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .kon       (kon),
        .egt       (egt),
        .ar        (ar),
        .dr        (dr),
        .sl        (sl),
        .rr        (rr),
        .att       (att)
    );

    waveform_lookup u_waveform_lookup (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .ws    (ws),
        .tl    (tl),
        .att   (att),
        .out   (out)
    );

    // three clocks of latency, matching the lookup pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[1:0], sample_en};
        end
    end

    assign sample_valid = valid_sr[2];

endmodule

/* tb/operator_tb.sv */
// OPL3 operator testbench

`timescale 1ns/1ps
`include "opl3_defs.svh"

module operator_tb;

    localparam int FIRST_GAP   = `SAMPLE_DIV + 3;  // first pulse plus pipeline
    localparam int RELEASE_MAX = 512 / 15 + 2;     // rr 15 back to silence
    localparam int SWEEP       = 512;              // one period at the slowest pitch
    localparam int VALID_WAIT  = 2 * `SAMPLE_DIV;  // clocks allowed per pulse

    logic                         clk;
    logic                         rst_n;
    logic                         kon;
    logic                         egt;
    logic [`FNUM_WIDTH-1:0]       fnum;
    logic [`MULT_WIDTH-1:0]       mult;
    logic [`BLOCK_WIDTH-1:0]      block;
    logic [`WS_WIDTH-1:0]         ws;
    logic [`ENV_WIDTH-1:0]        ar;
    logic [`ENV_WIDTH-1:0]        dr;
    logic [`ENV_WIDTH-1:0]        sl;
    logic [`ENV_WIDTH-1:0]        rr;
    logic [`TL_WIDTH-1:0]         tl;
    logic signed [`OUT_WIDTH-1:0] out;
    logic                         sample_valid;

    logic [31:0] rng_state;
    logic        expect_silence;  // out must read 0 at each pulse
    int          valid_gap;       // clocks since the last pulse
    logic        valid_seen;

    opl3_operator u_opl3_operator (.*);

    always #5 clk = ~clk;

    task automatic flag_mismatch(input string name, input longint got, input longint exp);
        $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic give_up(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // step of 2048 or more, so a sweep covers a whole period
    task automatic pick_pitch();
        rng_state = lcg_next(rng_state);
        fnum      = `FNUM_WIDTH'(256 + rng_state[31:16] % 768);
        rng_state = lcg_next(rng_state);
        block     = `BLOCK_WIDTH'(3 + rng_state[31:16] % 3);
        rng_state = lcg_next(rng_state);
        mult      = `MULT_WIDTH'(1 + rng_state[31:16] % 3);  // never 0
    endtask

    // returns on the falling edge inside the pulse, out is stable there
    task automatic wait_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!sample_valid) begin
            if (n >= VALID_WAIT) give_up("sample_valid did not pulse in time");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic measure_peak(output int peak);
        int v;
        peak = 0;
        repeat (SWEEP) begin
            wait_valid();
            v = (out < 0) ? -int'(out) : int'(out);
            if (v > peak) peak = v;
        end
    endtask

    // pulse spacing, counted from reset release for the first one
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_gap  <= 0;
            valid_seen <= 1'b0;
        end else if (sample_valid) begin
            a_period: assert (valid_gap == (valid_seen ? `SAMPLE_DIV : FIRST_GAP))
                else flag_mismatch("sample_valid gap", valid_gap,
                                   valid_seen ? `SAMPLE_DIV : FIRST_GAP);
            valid_gap  <= 1;
            valid_seen <= 1'b1;
        end else begin
            valid_gap <= valid_gap + 1;
        end
    end

    a_low_in_reset: assert property (@(posedge clk) !rst_n |-> !sample_valid)
        else flag_mismatch("sample_valid", 1, 0);
    a_one_wide: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else flag_mismatch("sample_valid", 1, 0);
    a_silent: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && expect_silence |-> out == 0)
        else flag_mismatch("out", $sampled(out), 0);
    a_no_negative: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && (ws == 2'd1 || ws == 2'd2) |-> out >= 0)
        else flag_mismatch("out (floor)", $sampled(out), 0);

    initial begin
        int   n;
        int   peak_full;
        int   peak_quiet;
        logic seen_pos;
        logic seen_neg;
        clk            = 1'b0;
        rst_n          = 1'b0;
        kon            = 1'b0;
        egt            = 1'b1;
        ws             = 2'd0;
        ar             = 4'd15;
        dr             = 4'd0;  // attack ends and holds at full level
        sl             = 4'd0;
        rr             = 4'd15;
        tl             = 6'd0;
        expect_silence = 1'b1;
        rng_state      = 32'hc3fa_246c;
        pick_pitch();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (8) wait_valid();  // kon low since reset

        kon            = 1'b1;
        expect_silence = 1'b0;
        n              = 0;
        wait_valid();
        while (out == 0) begin
            if (n >= 64) give_up("out stayed 0 after key on");
            n++;
            wait_valid();
        end

        repeat (16) wait_valid();  // attack done, att 0
        pick_pitch();
        seen_pos = 1'b0;
        seen_neg = 1'b0;
        n        = 0;
        while (!(seen_pos && seen_neg)) begin
            if (n >= 2 * SWEEP) give_up("full sine did not swing both ways");
            wait_valid();
            seen_pos = seen_pos | (out > 0);
            seen_neg = seen_neg | (out < 0);
            n++;
        end
        @(negedge clk);  // past the pulse, its sample was a full sine
        ws = 2'd1;
        repeat (SWEEP) wait_valid();
        ws = 2'd2;
        repeat (SWEEP) wait_valid();
        ws = 2'd0;

        dr = 4'd15;
        sl = 4'd4;  // sustain at att 128
        repeat (16) wait_valid();
        measure_peak(peak_full);
        tl = 6'd63;
        measure_peak(peak_quiet);
        a_tl_scale: assert (peak_quiet * 2 <= peak_full)
            else flag_mismatch("peak out at tl 63", peak_quiet, peak_full / 2);
        tl = 6'd0;

        kon = 1'b0;  // right after a pulse, so the next sample sees the edge
        repeat (RELEASE_MAX) wait_valid();
        a_released: assert (out == 0) else flag_mismatch("out", out, 0);
        expect_silence = 1'b1;
        repeat (16) wait_valid();
        repeat (2) @(posedge clk);  // last pulse reaches the assertions
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/opl3_pkg.sv
verilog/sample_clk_div.sv
operator/phase_generator.sv
operator/envelope_generator.sv
operator/waveform_lookup.sv
operator/opl3_operator.sv
tb/operator_tb.sv

/* Makefile */
# Verilator build and run for the OPL3 operator testbench

VERILATOR ?= verilator
TOP       ?= operator_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?=

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
